// File: bpu_pkg.sv
// Shared definitions for the branch prediction unit
// Address, index and tag widths, table sizes
// Branch-type and direction-counter enums
// Tag-folding function for the branch target buffer

package bpu_pkg;

    // ------------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------------

    // Word address, PC bits 31 down to 2
    localparam int PC_W        = 30;

    // Branch target buffer, direct mapped
    localparam int BTB_INDEX_W = 10;
    localparam int BTB_ENTRIES = 1 << BTB_INDEX_W;
    localparam int TAG_W       = 16;

    // Stored entry is tag, target and branch type
    localparam int BTB_DATA_W  = TAG_W + PC_W + 2;

    // Direction counter table
    localparam int PHT_INDEX_W = 10;
    localparam int PHT_ENTRIES = 1 << PHT_INDEX_W;

    // Return address stack
    localparam int RAS_DEPTH   = 8;
    localparam int RAS_PTR_W   = 3;
    // Count runs 0 to RAS_DEPTH, one bit wider than the pointer
    localparam int RAS_CNT_W   = RAS_PTR_W + 1;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------

    // Branch kinds held in the target buffer
    typedef enum logic [1:0] {
        BR_PC_RELATIVE = 2'b00,
        BR_CALL        = 2'b01,
        BR_RETURN      = 2'b10,
        BR_INDIRECT    = 2'b11
    } br_type_e;

    // 2-bit saturating counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_e;

    // Upper half of the word address folded onto the lower half,
    // lowest address bit appended
    function automatic logic [TAG_W-1:0] make_tag(input logic [PC_W-1:0] pc);
        return {pc[PC_W-1:PC_W/2] ^ pc[PC_W/2-1:0], pc[0]};
    endfunction

endpackage

// File: sdpram.sv
// Simple dual-port RAM
// One write port, one registered read port
// Read-first when both ports hit the same address

module sdpram #(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 48
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] raddr_i,
    input  logic [ADDR_WIDTH-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    // Storage array, contents undefined after power-up
    logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

    // Read register
    logic [DATA_WIDTH-1:0] rdata_q;

    // Read and write share one edge
    // Nonblocking update keeps the old word on the read side
    always_ff @(posedge clk) begin
        rdata_q <= mem[raddr_i];
        // Writes held off while in reset
        if (we_i && !reset) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: btb.sv
// Branch target buffer, direct mapped, one way
// Valid bits in flops, tag/target/type in a dual-port RAM
// Registered lookup tag and hit detection

module btb (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [bpu_pkg::PC_W-1:0]      rpc_i,
    input  logic                          update_i,
    input  logic [bpu_pkg::PC_W-1:0]      wpc_i,
    input  logic [bpu_pkg::PC_W-1:0]      bta_i,
    input  bpu_pkg::br_type_e             br_type_i,
    output logic                          hit_o,
    output logic [bpu_pkg::PC_W-1:0]      bta_o,
    output bpu_pkg::br_type_e             br_type_o
);

    // ------------------------------------------------------------------
    // Index and tag of both ports
    // ------------------------------------------------------------------

    logic [bpu_pkg::BTB_INDEX_W-1:0] rindex;
    logic [bpu_pkg::BTB_INDEX_W-1:0] windex;
    logic [bpu_pkg::TAG_W-1:0]       rtag;
    logic [bpu_pkg::TAG_W-1:0]       wtag;

    // Index from the low word-address bits
    assign rindex = rpc_i[bpu_pkg::BTB_INDEX_W-1:0];
    assign windex = wpc_i[bpu_pkg::BTB_INDEX_W-1:0];
    assign rtag   = bpu_pkg::make_tag(rpc_i);
    assign wtag   = bpu_pkg::make_tag(wpc_i);

    // ------------------------------------------------------------------
    // Valid bits and lookup registers
    // ------------------------------------------------------------------

    logic [bpu_pkg::BTB_ENTRIES-1:0] valid_bits;
    logic                            valid_q;
    logic [bpu_pkg::TAG_W-1:0]       rtag_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            // Old bit seen on a same-cycle write to the same index
            valid_q <= valid_bits[rindex];
            if (update_i) begin
                valid_bits[windex] <= 1'b1;
            end
        end
    end

    // Tag of the lookup, aligned with the RAM output
    always_ff @(posedge clk) begin
        rtag_q <= rtag;
    end

    // ------------------------------------------------------------------
    // Entry storage
    // ------------------------------------------------------------------

    logic [bpu_pkg::BTB_DATA_W-1:0] rd_entry;

    sdpram #(
        .ADDR_WIDTH (bpu_pkg::BTB_INDEX_W),
        .DATA_WIDTH (bpu_pkg::BTB_DATA_W)
    ) u_entries (
        .clk     (clk),
        .reset   (reset),
        .we_i    (update_i),
        .raddr_i (rindex),
        .waddr_i (windex),
        .wdata_i ({wtag, bta_i, br_type_i}),
        .rdata_o (rd_entry)
    );

    // Entry layout is tag, then target, then type in the low two bits
    assign hit_o     = valid_q && (rd_entry[bpu_pkg::BTB_DATA_W-1 -: bpu_pkg::TAG_W] == rtag_q);
    assign bta_o     = rd_entry[bpu_pkg::PC_W+1:2];
    assign br_type_o = bpu_pkg::br_type_e'(rd_entry[1:0]);

endmodule

// File: pht.sv
// Direction predictor table
// 2-bit saturating counters in flops, reset to weakly not taken
// Registered read, read-first against a same-cycle update

module pht (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [bpu_pkg::PC_W-1:0] rpc_i,
    input  logic                     update_i,
    input  logic [bpu_pkg::PC_W-1:0] wpc_i,
    input  logic                     taken_i,
    output logic                     taken_o
);

    // ------------------------------------------------------------------
    // Counter step
    // ------------------------------------------------------------------

    // Move one state toward taken or not taken, hold at the ends
    function automatic bpu_pkg::ctr_e next_ctr(input bpu_pkg::ctr_e cur,
                                               input logic taken);
        bpu_pkg::ctr_e nxt;
        nxt = cur;
        case (cur)
            bpu_pkg::STRONG_NT: nxt = taken ? bpu_pkg::WEAK_NT  : bpu_pkg::STRONG_NT;
            bpu_pkg::WEAK_NT:   nxt = taken ? bpu_pkg::WEAK_T   : bpu_pkg::STRONG_NT;
            bpu_pkg::WEAK_T:    nxt = taken ? bpu_pkg::STRONG_T : bpu_pkg::WEAK_NT;
            bpu_pkg::STRONG_T:  nxt = taken ? bpu_pkg::STRONG_T : bpu_pkg::WEAK_T;
            default:            nxt = bpu_pkg::WEAK_NT;
        endcase
        return nxt;
    endfunction

    // ------------------------------------------------------------------
    // Table
    // ------------------------------------------------------------------

    logic [bpu_pkg::PHT_INDEX_W-1:0] rindex;
    logic [bpu_pkg::PHT_INDEX_W-1:0] windex;

    bpu_pkg::ctr_e ctr_tbl [bpu_pkg::PHT_ENTRIES];
    bpu_pkg::ctr_e ctr_q;

    // Same low address bits as the target buffer
    assign rindex = rpc_i[bpu_pkg::PHT_INDEX_W-1:0];
    assign windex = wpc_i[bpu_pkg::PHT_INDEX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < bpu_pkg::PHT_ENTRIES; i++) begin
                ctr_tbl[i] <= bpu_pkg::WEAK_NT;
            end
            ctr_q <= bpu_pkg::WEAK_NT;
        end else begin
            // Read takes the value before this edge's update
            ctr_q <= ctr_tbl[rindex];
            if (update_i) begin
                ctr_tbl[windex] <= next_ctr(ctr_tbl[windex], taken_i);
            end
        end
    end

    // WEAK_T and STRONG_T both have the upper bit set
    assign taken_o = ctr_q[1];

endmodule

// File: ras.sv
// Return address stack
// Circular buffer with newest-entry pointer and occupancy count
// Overflow drops the oldest entry, count saturates at the depth

module ras (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push_i,
    input  logic [bpu_pkg::PC_W-1:0] push_addr_i,
    input  logic                     pop_i,
    output logic [bpu_pkg::PC_W-1:0] top_o,
    output logic                     empty_o
);

    // Return addresses, no reset needed
    logic [bpu_pkg::PC_W-1:0] stack [bpu_pkg::RAS_DEPTH];

    // Pointer to the newest entry
    logic [bpu_pkg::RAS_PTR_W-1:0] top_ptr;
    logic [bpu_pkg::RAS_PTR_W-1:0] push_ptr;
    logic [bpu_pkg::RAS_CNT_W-1:0] count;
    logic                          full;

    // Next slot wraps onto the oldest entry when full
    assign push_ptr = top_ptr + 1'b1;
    assign full     = (count == bpu_pkg::RAS_CNT_W'(bpu_pkg::RAS_DEPTH));
    assign empty_o  = (count == '0);

    // ------------------------------------------------------------------
    // Pointer and count
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (push_i) begin
            top_ptr <= push_ptr;
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (pop_i && !empty_o) begin
            // Pop on empty ignored
            top_ptr <= top_ptr - 1'b1;
            count   <= count - 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack[push_ptr] <= push_addr_i;
        end
    end

    // Newest entry, undefined while empty
    assign top_o = stack[top_ptr];

endmodule

// File: bpu_ctrl.sv
// Prediction control
// Lookup pipeline register and next-address selection
// Return stack push/pop in result cycles with a hit
// Update strobe qualification for the target buffer and counter table

module bpu_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     lookup_i,
    input  logic [bpu_pkg::PC_W-1:0] lookup_pc_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::PC_W-1:0] btb_bta_i,
    input  bpu_pkg::br_type_e        btb_type_i,
    input  logic                     pht_taken_i,
    input  logic [bpu_pkg::PC_W-1:0] ras_top_i,
    input  logic                     ras_empty_i,
    input  logic                     update_i,
    input  bpu_pkg::br_type_e        update_type_i,
    input  logic                     update_taken_i,
    output logic                     btb_we_o,
    output logic                     pht_we_o,
    output logic                     ras_push_o,
    output logic [bpu_pkg::PC_W-1:0] ras_push_addr_o,
    output logic                     ras_pop_o,
    output logic                     pred_valid_o,
    output logic                     pred_hit_o,
    output bpu_pkg::br_type_e        pred_type_o,
    output logic [bpu_pkg::PC_W-1:0] pred_target_o
);

    // ------------------------------------------------------------------
    // Lookup stage register
    // ------------------------------------------------------------------

    logic                     lookup_q;
    logic [bpu_pkg::PC_W-1:0] lookup_pc_q;
    logic [bpu_pkg::PC_W-1:0] fall_through;

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_i;
        end
    end

    // Address rides along with the table reads
    always_ff @(posedge clk) begin
        lookup_pc_q <= lookup_pc_i;
    end

    // Next sequential word
    assign fall_through = lookup_pc_q + 1'b1;

    // ------------------------------------------------------------------
    // Next-address selection
    // ------------------------------------------------------------------

    always_comb begin
        // Miss predicts straight-line fetch
        pred_type_o   = bpu_pkg::BR_PC_RELATIVE;
        pred_target_o = fall_through;
        if (btb_hit_i) begin
            pred_type_o = btb_type_i;
            case (btb_type_i)
                bpu_pkg::BR_PC_RELATIVE: pred_target_o = pht_taken_i ? btb_bta_i : fall_through;
                // Empty stack falls back to the stored target
                bpu_pkg::BR_RETURN:      pred_target_o = ras_empty_i ? btb_bta_i : ras_top_i;
                default:                 pred_target_o = btb_bta_i;
            endcase
        end
    end

    assign pred_valid_o = lookup_q;
    // Meaningful only while pred_valid_o is high
    assign pred_hit_o   = btb_hit_i;

    // Stack traffic only for real results that hit
    assign ras_push_o      = lookup_q && btb_hit_i && (btb_type_i == bpu_pkg::BR_CALL);
    assign ras_push_addr_o = fall_through;
    assign ras_pop_o       = lookup_q && btb_hit_i && (btb_type_i == bpu_pkg::BR_RETURN)
                             && !ras_empty_i;

    // Buffer learns taken branches, counters learn conditionals
    assign btb_we_o = update_i && update_taken_i;
    assign pht_we_o = update_i && (update_type_i == bpu_pkg::BR_PC_RELATIVE);

endmodule

// File: bpu_top.sv
// Branch prediction unit top level
// Control block with target buffer, counter table and return stack

module bpu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     lookup_i,
    input  logic [bpu_pkg::PC_W-1:0] lookup_pc_i,
    input  logic                     update_i,
    input  logic [bpu_pkg::PC_W-1:0] update_pc_i,
    input  logic [bpu_pkg::PC_W-1:0] update_target_i,
    input  bpu_pkg::br_type_e        update_type_i,
    input  logic                     update_taken_i,
    output logic                     pred_valid_o,
    output logic                     pred_hit_o,
    output bpu_pkg::br_type_e        pred_type_o,
    output logic [bpu_pkg::PC_W-1:0] pred_target_o
);

    // Table results
    logic                     btb_hit;
    logic [bpu_pkg::PC_W-1:0] btb_bta;
    bpu_pkg::br_type_e        btb_type;
    logic                     pht_taken;
    logic [bpu_pkg::PC_W-1:0] ras_top;
    logic                     ras_empty;

    // Control to tables
    logic                     btb_we;
    logic                     pht_we;
    logic                     ras_push;
    logic [bpu_pkg::PC_W-1:0] ras_push_addr;
    logic                     ras_pop;

    bpu_ctrl u_ctrl (
        .clk (clk), .reset (reset),
        .lookup_i (lookup_i), .lookup_pc_i (lookup_pc_i),
        .btb_hit_i (btb_hit), .btb_bta_i (btb_bta), .btb_type_i (btb_type),
        .pht_taken_i (pht_taken), .ras_top_i (ras_top), .ras_empty_i (ras_empty),
        .update_i (update_i), .update_type_i (update_type_i),
        .update_taken_i (update_taken_i),
        .btb_we_o (btb_we), .pht_we_o (pht_we),
        .ras_push_o (ras_push), .ras_push_addr_o (ras_push_addr), .ras_pop_o (ras_pop),
        .pred_valid_o (pred_valid_o), .pred_hit_o (pred_hit_o),
        .pred_type_o (pred_type_o), .pred_target_o (pred_target_o)
    );

    btb u_btb (
        .clk (clk), .reset (reset), .rpc_i (lookup_pc_i),
        .update_i (btb_we), .wpc_i (update_pc_i), .bta_i (update_target_i),
        .br_type_i (update_type_i),
        .hit_o (btb_hit), .bta_o (btb_bta), .br_type_o (btb_type)
    );

    pht u_pht (
        .clk (clk), .reset (reset), .rpc_i (lookup_pc_i),
        .update_i (pht_we), .wpc_i (update_pc_i), .taken_i (update_taken_i),
        .taken_o (pht_taken)
    );

    ras u_ras (
        .clk (clk), .reset (reset),
        .push_i (ras_push), .push_addr_i (ras_push_addr), .pop_i (ras_pop),
        .top_o (ras_top), .empty_o (ras_empty)
    );

endmodule

// File: bpu_chk.sv
// Bound assertions on the prediction control block
// Result strobe timing, stack push/pop exclusion, state after reset

module bpu_chk (
    input logic clk,
    input logic reset,
    input logic lookup_i,
    input logic pred_valid_i,
    input logic ras_push_i,
    input logic ras_pop_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Result strobe one cycle after each lookup strobe
    a_valid_follows_lookup: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (pred_valid_i == $past(lookup_i)))
        else $error("pred_valid_o does not follow lookup_i by one cycle");

    // A result is either a call or a return, never both
    a_push_pop_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ras_push_i && ras_pop_i))
        else $error("stack push and pop active in the same cycle");

    // No stale result right after reset
    a_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !pred_valid_i)
        else $error("pred_valid_o high in the first cycle after reset");

endmodule

bind bpu_ctrl bpu_chk u_chk (
    .clk (clk), .reset (reset), .lookup_i (lookup_i), .pred_valid_i (pred_valid_o),
    .ras_push_i (ras_push_o), .ras_pop_i (ras_pop_o)
);

// File: bpu_tb.sv
// Testbench for the branch prediction unit
// Directed and random lookups/updates checked against a reference model
// Compare tasks, per-test counts, cycle-limit timeout

module bpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RANDOM    = 3000;
    // One cycle per step, plus one idle step closing each test
    localparam int TEST_CYCLES = 32 + 96 + 25 + 34 + 16 + N_RANDOM + 6;
    localparam int CYCLE_LIMIT = 16 + TEST_CYCLES + 200;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     lookup_i;
    logic [bpu_pkg::PC_W-1:0] lookup_pc_i;
    logic                     update_i;
    logic [bpu_pkg::PC_W-1:0] update_pc_i;
    logic [bpu_pkg::PC_W-1:0] update_target_i;
    bpu_pkg::br_type_e        update_type_i;
    logic                     update_taken_i;
    logic                     pred_valid_o;
    logic                     pred_hit_o;
    bpu_pkg::br_type_e        pred_type_o;
    logic [bpu_pkg::PC_W-1:0] pred_target_o;

    // ------------------------------------------------------------------
    // Reference model state
    // ------------------------------------------------------------------

    logic                      m_valid [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::TAG_W-1:0] m_tag   [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::PC_W-1:0]  m_bta   [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::br_type_e         m_type  [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::ctr_e             m_ctr   [bpu_pkg::PHT_ENTRIES];
    // Newest return address at the back
    logic [bpu_pkg::PC_W-1:0]  m_stack [$];

    // Expected result of the lookup driven in the previous step
    logic                     exp_valid = 1'b0;
    logic                     exp_hit;
    bpu_pkg::br_type_e        exp_type;
    logic [bpu_pkg::PC_W-1:0] exp_target;

    int n_checks = 0;
    int n_errors = 0;
    int chk_mark = 0;
    int err_mark = 0;
    int cycles   = 0;

    always #50 clk = ~clk;

    bpu_top UUT (
        .clk (clk), .reset (reset),
        .lookup_i (lookup_i), .lookup_pc_i (lookup_pc_i),
        .update_i (update_i), .update_pc_i (update_pc_i),
        .update_target_i (update_target_i), .update_type_i (update_type_i),
        .update_taken_i (update_taken_i),
        .pred_valid_o (pred_valid_o), .pred_hit_o (pred_hit_o),
        .pred_type_o (pred_type_o), .pred_target_o (pred_target_o)
    );

    // Hard stop if the run goes past its cycle budget
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: run timed out after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic check_target(input logic [bpu_pkg::PC_W-1:0] got,
                                input logic [bpu_pkg::PC_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: target got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_type(input bpu_pkg::br_type_e got, input bpu_pkg::br_type_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: type got %s expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // Model
    // ------------------------------------------------------------------

    // Expected result, stack effects applied in lookup order
    task automatic predict(input logic lk, input logic [bpu_pkg::PC_W-1:0] pc);
        logic [bpu_pkg::BTB_INDEX_W-1:0] idx;
        logic [bpu_pkg::PHT_INDEX_W-1:0] pidx;
        idx        = pc[bpu_pkg::BTB_INDEX_W-1:0];
        pidx       = pc[bpu_pkg::PHT_INDEX_W-1:0];
        exp_valid  = lk;
        exp_hit    = m_valid[idx] && (m_tag[idx] == bpu_pkg::make_tag(pc));
        exp_type   = bpu_pkg::BR_PC_RELATIVE;
        exp_target = pc + 30'd1;
        if (lk && exp_hit) begin
            exp_type = m_type[idx];
            case (m_type[idx])
                bpu_pkg::BR_PC_RELATIVE: begin
                    if (m_ctr[pidx] >= bpu_pkg::WEAK_T) exp_target = m_bta[idx];
                end
                bpu_pkg::BR_CALL: begin
                    exp_target = m_bta[idx];
                    m_stack.push_back(pc + 30'd1);
                    // Oldest entry lost on overflow
                    if (m_stack.size() > bpu_pkg::RAS_DEPTH) void'(m_stack.pop_front());
                end
                bpu_pkg::BR_RETURN: begin
                    if (m_stack.size() == 0) begin
                        exp_target = m_bta[idx];
                    end else begin
                        exp_target = m_stack[$];
                        void'(m_stack.pop_back());
                    end
                end
                default: exp_target = m_bta[idx];
            endcase
        end
    endtask

    task automatic train(input logic [bpu_pkg::PC_W-1:0] pc,
                         input logic [bpu_pkg::PC_W-1:0] tgt,
                         input bpu_pkg::br_type_e ty, input logic taken);
        logic [bpu_pkg::BTB_INDEX_W-1:0] idx;
        logic [bpu_pkg::PHT_INDEX_W-1:0] pidx;
        idx  = pc[bpu_pkg::BTB_INDEX_W-1:0];
        pidx = pc[bpu_pkg::PHT_INDEX_W-1:0];
        if (taken) begin
            m_valid[idx] = 1'b1;
            m_tag[idx]   = bpu_pkg::make_tag(pc);
            m_bta[idx]   = tgt;
            m_type[idx]  = ty;
        end
        // Counters train on conditionals only, both directions
        if (ty == bpu_pkg::BR_PC_RELATIVE) begin
            if (taken && m_ctr[pidx] != bpu_pkg::STRONG_T)
                m_ctr[pidx] = bpu_pkg::ctr_e'(m_ctr[pidx] + 2'd1);
            else if (!taken && m_ctr[pidx] != bpu_pkg::STRONG_NT)
                m_ctr[pidx] = bpu_pkg::ctr_e'(m_ctr[pidx] - 2'd1);
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    // Eight addresses, pairs 2k and 2k+1 share an index with different tags
    function automatic logic [bpu_pkg::PC_W-1:0] pool_pc(input logic [2:0] n);
        return {(n[0] ? 20'h12345 : 20'h00012), n[2:1], 8'h35};
    endfunction

    function automatic logic [bpu_pkg::PC_W-1:0] rnd_pc();
        return pool_pc(3'($urandom_range(0, 7)));
    endfunction

    function automatic logic [bpu_pkg::PC_W-1:0] rnd_tgt();
        return bpu_pkg::PC_W'($urandom);
    endfunction

    function automatic bpu_pkg::br_type_e rnd_type();
        return bpu_pkg::br_type_e'(2'($urandom_range(0, 3)));
    endfunction

    // One cycle: drive, check the previous lookup, advance the model
    task automatic step(input logic lk, input logic [bpu_pkg::PC_W-1:0] lpc,
                        input logic up, input logic [bpu_pkg::PC_W-1:0] upc,
                        input logic [bpu_pkg::PC_W-1:0] tgt,
                        input bpu_pkg::br_type_e ty, input logic taken);
        @(posedge clk);
        lookup_i        <= lk;
        lookup_pc_i     <= lpc;
        update_i        <= up;
        update_pc_i     <= upc;
        update_target_i <= tgt;
        update_type_i   <= ty;
        update_taken_i  <= taken;
        @(negedge clk);
        check_hit(pred_valid_o, exp_valid, "pred_valid_o");
        if (exp_valid) begin
            check_hit(pred_hit_o, exp_hit, "pred_hit_o");
            check_type(pred_type_o, exp_type);
            check_target(pred_target_o, exp_target);
        end
        predict(lk, lpc);
        if (up) train(upc, tgt, ty, taken);
    endtask

    task automatic idle_step();
        step(1'b0, '0, 1'b0, '0, '0, bpu_pkg::BR_PC_RELATIVE, 1'b0);
    endtask

    task automatic lookup_step(input logic [bpu_pkg::PC_W-1:0] pc);
        step(1'b1, pc, 1'b0, '0, '0, bpu_pkg::BR_PC_RELATIVE, 1'b0);
    endtask

    // Idle step drains the last result before the counts are taken
    task automatic end_test(input string name);
        idle_step();
        $display("%-12s %0d checks, %0d errors", name, n_checks - chk_mark,
                 n_errors - err_mark);
        chk_mark = n_checks;
        err_mark = n_errors;
    endtask

    initial begin
        logic [bpu_pkg::PC_W-1:0] pc;
        void'($urandom(32'h3bd9));
        reset           = 1'b1;
        lookup_i        = 1'b0;
        lookup_pc_i     = '0;
        update_i        = 1'b0;
        update_pc_i     = '0;
        update_target_i = '0;
        update_type_i   = bpu_pkg::BR_PC_RELATIVE;
        update_taken_i  = 1'b0;
        for (int i = 0; i < bpu_pkg::BTB_ENTRIES; i++) m_valid[i] = 1'b0;
        for (int i = 0; i < bpu_pkg::PHT_ENTRIES; i++) m_ctr[i] = bpu_pkg::WEAK_NT;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 32; i++) lookup_step(rnd_pc());
        end_test("reset_state");

        // Mixed taken and not-taken updates, aliasing pairs in the pool
        for (int i = 0; i < 48; i++) begin
            pc = rnd_pc();
            step(1'b0, '0, 1'b1, pc, rnd_tgt(), rnd_type(), 1'($urandom_range(0, 1)));
            lookup_step(pc);
        end
        end_test("btb_train");

        // Up to STRONG_T, down to STRONG_NT, back up
        pc = pool_pc(3'd3);
        step(1'b0, '0, 1'b1, pc, rnd_tgt(), bpu_pkg::BR_PC_RELATIVE, 1'b1);
        for (int i = 0; i < 12; i++) begin
            step(1'b0, '0, 1'b1, pc, rnd_tgt(), bpu_pkg::BR_PC_RELATIVE, (i < 4) || (i >= 8));
            lookup_step(pc);
        end
        end_test("ctr_sat")

;

        // Calls at three indexes, one return; drain, then overflow and unwind
        for (int i = 0; i < 3; i++)
            step(1'b0, '0, 1'b1, pool_pc(3'(2 * i)), rnd_tgt(), bpu_pkg::BR_CALL, 1'b1);
        step(1'b0, '0, 1'b1, pool_pc(3'd6), rnd_tgt(), bpu_pkg::BR_RETURN, 1'b1);
        for (int i = 0; i < 10; i++) lookup_step(pool_pc(3'd6));
        // Ten calls, two past the depth, so the kept entries differ from the first eight
        for (int i = 0; i < 10; i++) lookup_step(pool_pc(3'(2 * (i % 3))));
        for (int i = 0; i < 10; i++) lookup_step(pool_pc(3'd6));
        end_test("ras_stack");

        for (int i = 0; i < 16; i++) begin
            pc = rnd_pc();
            step(1'b1, pc, 1'b1, pc, rnd_tgt(), rnd_type(), 1'b1);
        end
        end_test("same_cycle");

        for (int i = 0; i < N_RANDOM; i++)
            step(1'($urandom_range(0, 1)), rnd_pc(), 1'($urandom_range(0, 1)), rnd_pc(),
                 rnd_tgt(), rnd_type(), 1'($urandom_range(0, 1)));
        end_test("random_mix");

        $display("Totals: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: bpu.f
bpu_pkg.sv
sdpram.sv
btb.sv
pht.sv
ras.sv
bpu_ctrl.sv
bpu_top.sv
bpu_chk.sv
bpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= bpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
